/* sm83Slice.f */
+incdir+sim
logic/sm83Pkg.sv
logic/fetchQueue.sv
logic/opDecoder.sv
logic/aluCore.sv
logic/resultPort.sv
logic/sm83Slice.sv
sim/sm83SliceTb.sv

/* Makefile */
TOP = sm83SliceTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sm83Slice.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/sm83SliceTasks.svh */
// Testbench driver, check and test tasks
`ifndef SM83_SLICE_TASKS_SVH
`define SM83_SLICE_TASKS_SVH

	// One xorshift32 step.
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic hasImmediate(input logic [7:0] code);
		return code inside {OpAddN, OpAdcN, OpSubN, OpSbcN, OpAndN, OpXorN, OpOrN, OpCpN};
	endfunction

	// Random stream opcode table, two unlisted codes at the end.
	function automatic logic [7:0] pickOpcode(input logic [3:0] sel);
		case (sel)
			4'd0: return OpAddN;
			4'd1: return OpAdcN;
			4'd2: return OpSubN;
			4'd3: return OpSbcN;
			4'd4: return OpAndN;
			4'd5: return OpXorN;
			4'd6: return OpOrN;
			4'd7: return OpCpN;
			4'd8: return OpIncA;
			4'd9: return OpDecA;
			4'd10: return OpCpl;
			4'd11: return OpScf;
			4'd12: return OpCcf;
			4'd13: return OpNop;
			4'd14: return 8'h76;
			default: return 8'hAF;
		endcase
	endfunction

	task automatic checkRecord(input resultRecT got, input resultRecT exp);
		if (got.opcode !== exp.opcode) begin
			abortRun($sformatf("[ERROR] result.opcode got 0x%h expected 0x%h",
				got.opcode, exp.opcode));
		end
		if (got.acc !== exp.acc) begin
			abortRun($sformatf("[ERROR] result.acc got 0x%h expected 0x%h (opcode 0x%h)",
				got.acc, exp.acc, exp.opcode));
		end
		if (got.flags !== exp.flags) begin
			abortRun($sformatf("[ERROR] result.flags got 0x%h expected 0x%h (opcode 0x%h)",
				got.flags, exp.flags, exp.opcode));
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp) begin
			abortRun($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// Called at 1 ns after an edge, returns at the same point one byte later.
	task automatic sendByte(input logic [7:0] data);
		int cycles;
		cycles = 0;
		while (inCredits == 0) begin
			@(posedge CLK);
			#1;
			cycles++;
			if (cycles > Timeout) begin
				abortRun("timed out waiting for an input credit");
			end
		end
		byteValid = 1'b1;
		byteData = data;
		inCredits--;                 // Spent with this byte.
		sentBytes++;
		@(posedge CLK);
		#1;
		byteValid = 1'b0;
	endtask

	task automatic sendInstr(input logic [7:0] code, input logic [7:0] imm);
		expected.push_back(modelExec(code, imm));
		sendByte(code);
		if (hasImmediate(code)) begin
			sendByte(imm);
		end
	endtask

	// Load A through AND 0 then OR value.
	task automatic setAcc(input logic [7:0] value);
		sendInstr(OpAndN, 8'h00);
		sendInstr(OpOrN, value);
	endtask

	task automatic returnCredit();
		resultCredit = 1'b0;
		if (sinkOwed > 0 && sinkMode != sinkHold) begin
			if (sinkMode == sinkRandom && sinkGap > 0) begin
				sinkGap--;
			end else begin
				resultCredit = 1'b1;
				sinkOwed--;
				if (sinkMode == sinkRandom) begin
					sinkRng = xorshift(sinkRng);
					sinkGap = int'(sinkRng[2:0]);   // Zero to seven idle cycles.
				end
			end
		end
	endtask

	// Wait until every record is back and the sink owes nothing.
	task automatic waitIdle();
		int cycles;
		cycles = 0;
		while (expected.size() != 0 || sinkOwed != 0) begin
			@(posedge CLK);
			#3;
			cycles++;
			if (cycles > Timeout) begin
				abortRun("timed out waiting for the DUT to drain");
			end
		end
		@(posedge CLK);              // Last credit reaches the DUT.
		#1;
	endtask

	task automatic quietAfterReset();
		repeat (20) @(posedge CLK);
		#1;
		checkCount("resultValid pulses after reset", recSeen, 0);
		checkCount("byteCredit pulses after reset", creditsBack, 0);
	endtask

	task automatic immediateOpsSweep();
		logic [7:0] ops [8];
		logic [7:0] edges [4];
		ops = '{OpAddN, OpAdcN, OpSubN, OpSbcN, OpAndN, OpXorN, OpOrN, OpCpN};
		edges = '{8'h00, 8'h0F, 8'h10, 8'hFF};
		for (int i = 0; i < 8; i++) begin
			for (int j = 0; j < 4; j++) begin
				for (int k = 0; k < 4; k++) begin
					setAcc(edges[j]);
					if ((j + k) % 2 == 1) begin
						sendInstr(OpScf, 8'h00);   // Carry in for ADC and SBC.
					end
					sendInstr(ops[i], edges[k]);
				end
			end
		end
		waitIdle();
	endtask

	task automatic oneByteOps();
		setAcc(8'hFF);
		sendInstr(OpIncA, 8'h00);      // Wraps to zero with H.
		sendInstr(OpScf, 8'h00);
		sendInstr(OpIncA, 8'h00);      // C kept.
		setAcc(8'h01);
		sendInstr(OpScf, 8'h00);
		sendInstr(OpDecA, 8'h00);      // Reaches zero.
		sendInstr(OpDecA, 8'h00);      // Nibble borrow, 0x00 to 0xFF.
		sendInstr(OpCpl, 8'h00);
		sendInstr(OpCcf, 8'h00);
		sendInstr(OpCcf, 8'h00);
		sendInstr(8'h76, 8'h00);       // Unlisted, runs as NOP.
		sendInstr(OpNop, 8'h00);
		sendInstr(8'hAF, 8'h00);
		waitIdle();
	endtask

	task automatic inputCreditBurst();
		int creditBase;
		creditBase = creditsBack;
		for (int i = 0; i < 20; i++) begin
			sendInstr(OpAddN, 8'(i * 13));
		end
		waitIdle();
		checkCount("byteCredit pulses in burst", creditsBack - creditBase, 40);
	endtask

	task automatic outputBackPressure();
		int base;
		sinkMode = sinkHold;
		base = recSeen;
		for (int i = 0; i < 6; i++) begin
			sendInstr(OpIncA, 8'h00);
		end
		repeat (30) @(posedge CLK);
		#1;
		checkCount("records while credits withheld", recSeen - base, ResultCredits);
		sinkMode = sinkEager;
		waitIdle();
	endtask

	task automatic randomStream();
		logic [7:0] code;
		sinkMode = sinkRandom;
		for (int i = 0; i < 200; i++) begin
			stimRng = xorshift(stimRng);
			code = pickOpcode(stimRng[3:0]);
			sendInstr(code, stimRng[15:8]);
		end
		waitIdle();
		sinkMode = sinkEager;
		checkCount("byteCredit pulses in total", creditsBack, sentBytes);
	endtask

`endif

/* sim/sm83SliceTb.sv */
// SM83 slice testbench
`timescale 1ns/100ps
`default_nettype none

module sm83SliceTb;
	import sm83Pkg::*;

	typedef enum {sinkEager, sinkHold, sinkRandom} sinkModeT;

	localparam logic [31:0] Seed = 32'h3f270c3e;
	localparam int Timeout = 2000;       // Cycles one wait may take.

	logic CLK;
	logic reset;
	logic byteValid;
	logic [7:0] byteData;
	logic byteCredit;
	resultRecT result;
	logic resultValid;
	logic resultCredit;

	resultRecT expected [$];     // Records the DUT still owes, oldest first.
	logic [7:0] modelAcc;        // Reference copy of A.
	flagsT modelFlags;           // Reference copy of the flags.
	int inCredits;               // Input credits held by the producer.
	int creditsBack;             // byteCredit pulses seen.
	int sentBytes;
	int recSeen;                 // Result records seen.
	int sinkOwed;                // Output credits not yet returned.
	sinkModeT sinkMode;
	int sinkGap;                 // Idle cycles before the next return.
	logic [31:0] stimRng;        // Stimulus generator state.
	logic [31:0] sinkRng;        // Sink gap generator state.

	sm83Slice dut_i (
		.CLK(CLK),
		.reset(reset),
		.byteValid(byteValid),
		.byteData(byteData),
		.byteCredit(byteCredit),
		.result(result),
		.resultValid(resultValid),
		.resultCredit(resultCredit)
	);

	always #5 CLK = ~CLK;        // 10 ns period.

	`include "sm83SliceTasks.svh"

	// Print the reason, then end the run.
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	// Reference model, advances modelAcc and modelFlags.
	function automatic resultRecT modelExec(input logic [7:0] code, input logic [7:0] imm);
		int full;                  // Wide result, negative on borrow.
		int half;                  // Low nibble result.
		int cin;
		logic [7:0] a;
		flagsT f;
		a = modelAcc;
		f = modelFlags;
		cin = ((code == OpAdcN || code == OpSbcN) && f.c) ? 1 : 0;
		case (code)
			OpAddN, OpAdcN: begin
				full = int'(a) + int'(imm) + cin;
				half = int'(a[3:0]) + int'(imm[3:0]) + cin;
				a = full[7:0];
				f = '{z: (a == 8'h00), n: 1'b0, h: (half > 15), c: (full > 255)};
			end
			OpSubN, OpSbcN, OpCpN: begin
				full = int'(a) - int'(imm) - cin;
				half = int'(a[3:0]) - int'(imm[3:0]) - cin;
				f = '{z: (full[7:0] == 8'h00), n: 1'b1, h: (half < 0), c: (full < 0)};
				if (code != OpCpN) begin
					a = full[7:0];     // CP only sets flags.
				end
			end
			OpAndN: begin
				a = a & imm;
				f = '{z: (a == 8'h00), n: 1'b0, h: 1'b1, c: 1'b0};
			end
			OpXorN, OpOrN: begin
				a = (code == OpXorN) ? (a ^ imm) : (a | imm);
				f = '{z: (a == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
			end
			OpIncA: begin
				f.h = (a[3:0] == 4'hF);  // Carry into bit 4.
				a = a + 8'd1;
				f.z = (a == 8'h00);
				f.n = 1'b0;
			end
			OpDecA: begin
				f.h = (a[3:0] == 4'h0);  // Borrow from bit 4.
				a = a - 8'd1;
				f.z = (a == 8'h00);
				f.n = 1'b1;
			end
			OpCpl: begin
				a = ~a;
				f.n = 1'b1;
				f.h = 1'b1;
			end
			OpScf: f = '{z: f.z, n: 1'b0, h: 1'b0, c: 1'b1};
			OpCcf: f = '{z: f.z, n: 1'b0, h: 1'b0, c: !f.c};
			default: f = modelFlags; // NOP and unlisted opcodes.
		endcase
		modelAcc = a;
		modelFlags = f;
		return '{opcode: code, acc: a, flags: f};
	endfunction

	// Outputs sampled mid cycle, away from the clock edge.
	always @(negedge CLK) begin
		if (!reset) begin
			if (byteCredit) begin
				creditsBack++;
				inCredits++;
				if (inCredits > QueueDepth) begin
					abortRun("more input credits came back than bytes were sent");
				end
			end
			if (resultValid) begin
				recSeen++;
				sinkOwed++;          // Sink now owes one credit.
				if (expected.size() == 0) begin
					abortRun("result record arrived while none was expected");
				end else begin
					checkRecord(result, expected.pop_front());
				end
			end
		end
	end

	// Output sink, one decision per cycle.
	always begin
		@(posedge CLK);
		#1;
		returnCredit();
	end

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		byteValid = 1'b0;
		byteData = 8'h00;
		resultCredit = 1'b0;
		modelAcc = 8'h00;          // A and flags clear after reset.
		modelFlags = '0;
		inCredits = QueueDepth;
		creditsBack = 0;
		sentBytes = 0;
		recSeen = 0;
		sinkOwed = 0;
		sinkMode = sinkEager;
		sinkGap = 0;
		stimRng = Seed;
		sinkRng = ~Seed;
		repeat (4) @(posedge CLK);
		#1;
		reset = 1'b0;
		quietAfterReset();
		immediateOpsSweep();
		oneByteOps();
		inputCreditBurst();
		outputBackPressure();
		randomStream();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/sm83Slice.sv */
// SM83 fetch, decode and ALU slice
`timescale 1ns/100ps
`default_nettype none

module sm83Slice (
	input logic CLK,
	input logic reset,
	input logic byteValid,
	input logic [7:0] byteData,
	output logic byteCredit,
	output sm83Pkg::resultRecT result,
	output logic resultValid,
	input logic resultCredit
);
	import sm83Pkg::*;

	logic [7:0] head;       // Queue head byte.
	logic headValid;
	logic pop;
	aluReqT req;            // Decoder to ALU.
	logic reqValid;
	logic reqReady;
	resultRecT rec;         // ALU to output side.
	logic recValid;
	logic recReady;

	fetchQueue fetchQueueInst (
		.CLK(CLK),
		.reset(reset),
		.byteValid(byteValid),
		.byteData(byteData),
		.byteCredit(byteCredit),
		.head(head),
		.headValid(headValid),
		.pop(pop)
	);

	opDecoder opDecoderInst (
		.CLK(CLK),
		.reset(reset),
		.head(head),
		.headValid(headValid),
		.pop(pop),
		.req(req),
		.reqValid(reqValid),
		.reqReady(reqReady)
	);

	aluCore aluCoreInst (
		.CLK(CLK),
		.reset(reset),
		.req(req),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.rec(rec),
		.recValid(recValid),
		.recReady(recReady)
	);

	resultPort resultPortInst (
		.CLK(CLK),
		.reset(reset),
		.rec(rec),
		.recValid(recValid),
		.recReady(recReady),
		.result(result),
		.resultValid(resultValid),
		.resultCredit(resultCredit)
	);

endmodule

`default_nettype wire

/* logic/resultPort.sv */
// Credited result output
`timescale 1ns/100ps
`default_nettype none

module resultPort (
	input logic CLK,
	input logic reset,
	input sm83Pkg::resultRecT rec,
	input logic recValid,
	output logic recReady,
	output sm83Pkg::resultRecT result,
	output logic resultValid,
	input logic resultCredit
);
	import sm83Pkg::*;

	logic [CreditW-1:0] credits;    // Records the sink can still take.
	logic send;                     // Record accepted and spent a credit.

	assign recReady = (credits != '0);    // Stall the ALU when out of credit.
	assign send = recValid && recReady;

	always_ff @(posedge CLK) begin
		if (reset) begin
			credits <= CreditW'(ResultCredits);
			resultValid <= 1'b0;
		end else begin
			resultValid <= send;      // One-cycle pulse per record.
			case ({send, resultCredit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;   // Spent and returned together.
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (send) begin
			result <= rec;
		end
	end

	// Sink never returns more credits than it granted.
	assert property (@(posedge CLK) disable iff (reset)
		credits <= CreditW'(ResultCredits));

endmodule

`default_nettype wire

/* logic/aluCore.sv */
// Accumulator ALU with flag register
`timescale 1ns/100ps
`default_nettype none

module aluCore (
	input logic CLK,
	input logic reset,
	input sm83Pkg::aluReqT req,
	input logic reqValid,
	output logic reqReady,
	output sm83Pkg::resultRecT rec,
	output logic recValid,
	input logic recReady
);
	import sm83Pkg::*;

	logic [7:0] acc;          // Register A.
	flagsT flags;             // Z, N, H, C.
	logic [7:0] recOpcode;    // Opcode of the held record.
	logic xfer;               // Request accepted this cycle.
	logic carryIn;            // Old carry for ADC and SBC.
	logic [8:0] sum;
	logic [4:0] halfSum;
	logic [8:0] diff;
	logic [4:0] halfDiff;
	logic [7:0] logicRes;     // AND, XOR or OR result.
	logic [7:0] nextAcc;
	flagsT nextFlags;

	assign reqReady = !recValid || recReady;
	assign xfer = reqValid && reqReady;
	assign rec = '{opcode: recOpcode, acc: acc, flags: flags};

	assign carryIn = (req.op == aluAdc || req.op == aluSbc) ? flags.c : 1'b0;
	assign sum = {1'b0, acc} + {1'b0, req.operand} + {8'd0, carryIn};
	assign halfSum = {1'b0, acc[3:0]} + {1'b0, req.operand[3:0]} + {4'd0, carryIn};
	assign diff = {1'b0, acc} - {1'b0, req.operand} - {8'd0, carryIn};      // Bit 8 is borrow.
	assign halfDiff = {1'b0, acc[3:0]} - {1'b0, req.operand[3:0]} - {4'd0, carryIn};

	always_comb begin
		case (req.op)
			aluAnd: logicRes = acc & req.operand;
			aluXor: logicRes = acc ^ req.operand;
			default: logicRes = acc | req.operand;
		endcase
	end

	always_comb begin
		nextAcc = acc;          // NOP and CP keep A.
		nextFlags = flags;
		case (req.op)
			aluAdd, aluAdc: begin
				nextAcc = sum[7:0];
				nextFlags = '{z: (sum[7:0] == 8'h00), n: 1'b0, h: halfSum[4], c: sum[8]};
			end
			aluSub, aluSbc, aluCp: begin
				if (req.op != aluCp) begin
					nextAcc = diff[7:0];
				end
				nextFlags = '{z: (diff[7:0] == 8'h00), n: 1'b1, h: halfDiff[4], c: diff[8]};
			end
			aluAnd: begin
				nextAcc = logicRes;
				nextFlags = '{z: (logicRes == 8'h00), n: 1'b0, h: 1'b1, c: 1'b0};
			end
			aluXor, aluOr: begin
				nextAcc = logicRes;
				nextFlags = '{z: (logicRes == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
			end
			aluInc: begin
				nextAcc = acc + 8'd1;
				nextFlags = '{z: (acc == 8'hFF), n: 1'b0, h: (acc[3:0] == 4'hF), c: flags.c};
			end
			aluDec: begin
				nextAcc = acc - 8'd1;
				nextFlags = '{z: (acc == 8'h01), n: 1'b1, h: (acc[3:0] == 4'h0), c: flags.c};
			end
			aluCpl: begin
				nextAcc = ~acc;
				nextFlags = '{z: flags.z, n: 1'b1, h: 1'b1, c: flags.c};
			end
			aluScf: nextFlags = '{z: flags.z, n: 1'b0, h: 1'b0, c: 1'b1};
			aluCcf: nextFlags = '{z: flags.z, n: 1'b0, h: 1'b0, c: !flags.c};
			default: nextFlags = flags;   // NOP changes nothing.
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			acc <= 8'h00;
			flags <= '0;
			recValid <= 1'b0;
		end else if (xfer) begin
			acc <= nextAcc;       // A and flags move with the request.
			flags <= nextFlags;
			recValid <= 1'b1;
		end else if (recReady) begin
			recValid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (xfer) begin
			recOpcode <= req.opcode;
		end
	end

	// Stalled record is held unchanged.
	assert property (@(posedge CLK) disable iff (reset)
		recValid && !recReady |=> recValid && $stable(rec));

endmodule

`default_nettype wire

/* logic/opDecoder.sv */
// Opcode and immediate decoder
`timescale 1ns/100ps
`default_nettype none

module opDecoder (
	input logic CLK,
	input logic reset,
	input logic [7:0] head,
	input logic headValid,
	output logic pop,
	output sm83Pkg::aluReqT req,
	output logic reqValid,
	input logic reqReady
);
	import sm83Pkg::*;

	decStateT state;      // Waiting for opcode or for its immediate byte.
	logic regFree;        // Request register empty or leaving this cycle.
	logic lastByte;       // Popped byte completes an instruction.

	// Map an opcode to its ALU operation.
	function automatic aluOpT decodeOp(input logic [7:0] code);
		case (code)
			OpAddN: decodeOp = aluAdd;
			OpAdcN: decodeOp = aluAdc;
			OpSubN: decodeOp = aluSub;
			OpSbcN: decodeOp = aluSbc;
			OpAndN: decodeOp = aluAnd;
			OpXorN: decodeOp = aluXor;
			OpOrN:  decodeOp = aluOr;
			OpCpN:  decodeOp = aluCp;
			OpIncA: decodeOp = aluInc;
			OpDecA: decodeOp = aluDec;
			OpCpl:  decodeOp = aluCpl;
			OpScf:  decodeOp = aluScf;
			OpCcf:  decodeOp = aluCcf;
			default: decodeOp = aluNop;   // Unlisted opcodes run as NOP.
		endcase
	endfunction

	// True for opcodes followed by an immediate byte.
	function automatic logic immOp(input logic [7:0] code);
		case (code)
			OpAddN, OpAdcN, OpSubN, OpSbcN,
			OpAndN, OpXorN, OpOrN, OpCpN: immOp = 1'b1;
			default: immOp = 1'b0;
		endcase
	endfunction

	assign regFree = !reqValid || reqReady;
	assign pop = headValid && regFree;                 // Consume head as soon as it shows.
	assign lastByte = (state == decOperand) || !immOp(head);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= decOpcode;
			reqValid <= 1'b0;
		end else begin
			if (reqValid && reqReady) begin
				reqValid <= 1'b0;            // Request taken by the ALU.
			end
			if (pop) begin
				reqValid <= lastByte;        // Raise valid once the instruction is whole.
				state <= (lastByte) ? decOpcode : decOperand;
			end
		end
	end

	// Request payload, built in place while reqValid is low.
	always_ff @(posedge CLK) begin
		if (pop) begin
			if (state == decOpcode) begin
				req.op <= decodeOp(head);
				req.opcode <= head;
				req.operand <= 8'h00;        // Stays zero for one-byte ops.
			end else begin
				req.operand <= head;         // Immediate byte.
			end
		end
	end

endmodule

`default_nettype wire

/* logic/fetchQueue.sv */
// Credited instruction byte queue
`timescale 1ns/100ps
`default_nettype none

module fetchQueue (
	input logic CLK,
	input logic reset,
	input logic byteValid,
	input logic [7:0] byteData,
	output logic byteCredit,
	output logic [7:0] head,
	output logic headValid,
	input logic pop
);
	import sm83Pkg::*;

	logic [7:0] mem [QueueDepth];     // Byte storage, no reset.
	logic [QueuePtrW-1:0] wrPtr;      // Next slot to fill.
	logic [QueuePtrW-1:0] rdPtr;      // Current head slot.
	logic [QueuePtrW:0] count;        // Bytes held.

	assign head = mem[rdPtr];
	assign headValid = (count != '0);

	always_ff @(posedge CLK) begin
		if (byteValid) begin
			mem[wrPtr] <= byteData;     // Credited byte lands at this edge.
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			byteCredit <= 1'b0;
		end else begin
			byteCredit <= pop;          // One credit back per consumed byte.
			if (byteValid) begin
				wrPtr <= wrPtr + 1'b1;    // Wraps, depth is a power of two.
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({byteValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // Both or neither.
			endcase
		end
	end

	// Producer must hold a credit for every byte it sends.
	assert property (@(posedge CLK) disable iff (reset)
		!(byteValid && count == (QueuePtrW + 1)'(QueueDepth)));

	// Decoder only consumes a byte that is present.
	assert property (@(posedge CLK) disable iff (reset) pop |-> headValid);

endmodule

`default_nettype wire

/* logic/sm83Pkg.sv */
// SM83 slice shared definitions
`default_nettype none

package sm83Pkg;

	localparam int QueueDepth = 4;                        // Input byte slots and initial input credits.
	localparam int QueuePtrW = $clog2(QueueDepth);        // Queue pointer width.
	localparam int ResultCredits = 2;                     // Output credits granted by the sink.
	localparam int CreditW = $clog2(ResultCredits + 1);   // Output credit counter width.

	// Opcodes with an immediate byte.
	localparam logic [7:0] OpAddN = 8'hC6;
	localparam logic [7:0] OpAdcN = 8'hCE;
	localparam logic [7:0] OpSubN = 8'hD6;
	localparam logic [7:0] OpSbcN = 8'hDE;
	localparam logic [7:0] OpAndN = 8'hE6;
	localparam logic [7:0] OpXorN = 8'hEE;
	localparam logic [7:0] OpOrN  = 8'hF6;
	localparam logic [7:0] OpCpN  = 8'hFE;

	// One-byte opcodes.
	localparam logic [7:0] OpIncA = 8'h3C;
	localparam logic [7:0] OpDecA = 8'h3D;
	localparam logic [7:0] OpCpl  = 8'h2F;
	localparam logic [7:0] OpScf  = 8'h37;
	localparam logic [7:0] OpCcf  = 8'h3F;
	localparam logic [7:0] OpNop  = 8'h00;

	typedef enum logic [3:0] {
		aluAdd, aluAdc, aluSub, aluSbc, aluAnd, aluXor, aluOr, aluCp,
		aluInc, aluDec, aluCpl, aluScf, aluCcf, aluNop
	} aluOpT;

	typedef struct packed {
		logic z;    // Zero.
		logic n;    // Subtract.
		logic h;    // Half carry.
		logic c;    // Carry.
	} flagsT;

	typedef struct packed {
		aluOpT op;              // ALU operation.
		logic [7:0] operand;    // Immediate byte, zero for one-byte ops.
		logic [7:0] opcode;     // Raw opcode, carried into the record.
	} aluReqT;

	typedef struct packed {
		logic [7:0] opcode;     // Executed opcode.
		logic [7:0] acc;        // A after execution.
		flagsT flags;           // Flags after execution.
	} resultRecT;

	typedef enum logic {decOpcode, decOperand} decStateT;

endpackage

`default_nettype wire
